// ==== src/fifo_params.svh ====
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// Data width of one FIFO entry
`define FIFO_WIDTH 45

// SRAM geometry, two entries per word
`define SRAM_WORDS 64
`define SRAM_ADDR_W 6
`define SRAM_WORD_W 128
`define FIFO_DEPTH 128

// Half select, six address bits, wrap bit
`define PTR_W 8

`endif

// ==== src/fifo_pkg.sv ====
`include "fifo_params.svh"

package fifo_pkg;

    typedef logic [`FIFO_WIDTH-1:0] entry_t;
    typedef logic [`PTR_W-1:0] ptr_t;
    typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

    // Even entry in the low bits, unused bits on top
    typedef struct packed {
        logic [`SRAM_WORD_W-2*`FIFO_WIDTH-1:0] pad;
        entry_t                                odd;
        entry_t                                even;
    } entry_pair_t;

    // Raw on the memory side, a pair on the FIFO side
    typedef union packed {
        logic [`SRAM_WORD_W-1:0] raw;
        entry_pair_t             pair;
    } sram_word_u;

    typedef struct packed {
        logic       en;
        sram_addr_t addr;
        sram_word_u word;
    } sram_wr_req_t;

    typedef struct packed {
        logic       en;
        sram_addr_t addr;
    } sram_rd_req_t;

    typedef enum logic [1:0] {IDLE, WAIT_SRAM, WAIT_TAKE, NORMAL} rd_state_e;

endpackage

// ==== src/pair_sram.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module pair_sram (
    input  logic                   axis_clk,
    input  fifo_pkg::sram_wr_req_t wr_req_i,
    input  fifo_pkg::sram_rd_req_t rd_req_i,
    output logic                   rd_grant_o,
    output fifo_pkg::sram_word_u   rd_data_o
);

    logic [`SRAM_WORD_W-1:0] mem_q [`SRAM_WORDS];
    fifo_pkg::sram_addr_t    port_addr;

    // Writer owns the port whenever it asks
    assign rd_grant_o = rd_req_i.en & ~wr_req_i.en;

    // One address port shared by both sides
    assign port_addr = wr_req_i.en ? wr_req_i.addr : rd_req_i.addr;

    always_ff @(posedge axis_clk) begin
        if (wr_req_i.en) begin
            mem_q[port_addr] <= wr_req_i.word.raw;
        end
    end

    // Read word holds until the next granted read
    always_ff @(posedge axis_clk) begin
        if (rd_grant_o) begin
            rd_data_o.raw <= mem_q[port_addr];
        end
    end

endmodule

// ==== src/fifo_ptrs.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_ptrs (
    input  logic           axis_clk,
    input  logic           axi_reset_n,
    input  logic           w_vld_i,
    input  logic           r_rdy_i,
    input  logic           r_vld_i,
    output fifo_pkg::ptr_t w_ptr_o,
    output fifo_pkg::ptr_t r_ptr_o,
    output logic           empty_o,
    output logic           full_o,
    output logic           one_left_o
);

    fifo_pkg::ptr_t w_ptr_q;
    fifo_pkg::ptr_t r_ptr_q;
    fifo_pkg::ptr_t fill;
    logic           w_fire;
    logic           r_fire;

    assign w_fire = w_vld_i & ~full_o;
    assign r_fire = r_vld_i & r_rdy_i;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            w_ptr_q <= '0;
            r_ptr_q <= '0;
        end else begin
            if (w_fire) begin
                w_ptr_q <= w_ptr_q + 1'b1;
            end
            if (r_fire) begin
                r_ptr_q <= r_ptr_q + 1'b1;
            end
        end
    end

    assign fill = w_ptr_q - r_ptr_q;

    // Wrap bits differ while address and half bits match
    assign full_o     = (fill == fifo_pkg::ptr_t'(`FIFO_DEPTH));
    assign empty_o    = (w_ptr_q == r_ptr_q);
    assign one_left_o = (fifo_pkg::ptr_t'(r_ptr_q + 1'b1) == w_ptr_q);

    assign w_ptr_o = w_ptr_q;
    assign r_ptr_o = r_ptr_q;

endmodule

// ==== src/write_pairer.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module write_pairer (
    input  logic                   axis_clk,
    input  logic                   axi_reset_n,
    input  logic                   wr_fire_i,
    input  fifo_pkg::ptr_t         w_ptr_i,
    input  fifo_pkg::entry_t       data_i,
    output fifo_pkg::entry_t       held_o,
    output fifo_pkg::sram_wr_req_t wr_req_o
);

    fifo_pkg::entry_t held_q;

    // Last accepted entry, the even one while its partner is pending
    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            held_q <= '0;
        end else if (wr_fire_i) begin
            held_q <= data_i;
        end
    end

    // Odd entry completes the pair, written on its own accept edge
    always_comb begin
        wr_req_o.en             = wr_fire_i & w_ptr_i[0];
        wr_req_o.addr           = w_ptr_i[`PTR_W-2:1];
        wr_req_o.word.pair.pad  = '0;
        wr_req_o.word.pair.odd  = data_i;
        wr_req_o.word.pair.even = held_q;
    end

    assign held_o = held_q;

endmodule

// ==== src/read_sequencer.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module read_sequencer (
    input  logic                   axis_clk,
    input  logic                   axi_reset_n,
    input  logic                   r_rdy_i,
    input  fifo_pkg::ptr_t         r_ptr_i,
    input  fifo_pkg::ptr_t         w_ptr_i,
    input  logic                   empty_i,
    input  logic                   one_left_i,
    input  fifo_pkg::entry_t       held_i,
    input  logic                   rd_grant_i,
    input  fifo_pkg::sram_word_u   rd_data_i,
    output fifo_pkg::sram_rd_req_t rd_req_o,
    output logic                   r_vld_o,
    output fifo_pkg::entry_t       data_o
);

    fifo_pkg::rd_state_e state_q;
    fifo_pkg::rd_state_e state_d;
    fifo_pkg::entry_t    front_q;
    logic                front_vld_q;
    logic                word_ok_q;
    fifo_pkg::ptr_t      word_ptr;
    fifo_pkg::ptr_t      word_gap;
    logic                word_done;
    logic                even_sel;
    logic                take;
    logic                take_even;

    // Even entry of the word NORMAL needs next
    assign word_ptr = r_ptr_i + fifo_pkg::ptr_t'(r_ptr_i[0]);
    assign word_gap = w_ptr_i - word_ptr;
    // Both halves accepted, so the word is in the SRAM
    assign word_done = !empty_i && (word_gap >= fifo_pkg::ptr_t'(2));

    always_comb begin
        state_d = state_q;
        case (state_q)
            fifo_pkg::IDLE: begin
                // A stashed entry is drained before any SRAM access
                if (!empty_i && !one_left_i && !front_vld_q) begin
                    state_d = r_ptr_i[0] ? fifo_pkg::WAIT_SRAM : fifo_pkg::NORMAL;
                end
            end
            fifo_pkg::WAIT_SRAM: begin
                if (rd_grant_i) begin
                    state_d = fifo_pkg::WAIT_TAKE;
                end
            end
            fifo_pkg::WAIT_TAKE: begin
                if (r_rdy_i) begin
                    state_d = fifo_pkg::NORMAL;
                end
            end
            default: begin
                if (one_left_i || empty_i) begin
                    state_d = fifo_pkg::IDLE;
                end
            end
        endcase
    end

    always_comb begin
        rd_req_o.en   = 1'b0;
        rd_req_o.addr = r_ptr_i[`PTR_W-2:1];
        if (state_q == fifo_pkg::WAIT_SRAM) begin
            rd_req_o.en = 1'b1;
        end else if (state_q == fifo_pkg::NORMAL && !one_left_i && !word_ok_q) begin
            // Fetch ahead while the odd half is served
            rd_req_o.en   = word_done;
            rd_req_o.addr = word_ptr[`PTR_W-2:1];
        end
    end

    // Output source, highest priority first
    always_comb begin
        r_vld_o  = 1'b0;
        data_o   = held_i;
        even_sel = 1'b0;
        if (one_left_i) begin
            r_vld_o = 1'b1;
        end else if (front_vld_q) begin
            r_vld_o = 1'b1;
            data_o  = front_q;
        end else if (state_q == fifo_pkg::WAIT_TAKE) begin
            r_vld_o = 1'b1;
            data_o  = rd_data_i.pair.odd;
        end else if (state_q == fifo_pkg::NORMAL && !r_ptr_i[0]) begin
            r_vld_o  = word_ok_q;
            data_o   = rd_data_i.pair.even;
            even_sel = 1'b1;
        end
    end

    assign take      = r_vld_o & r_rdy_i;
    assign take_even = take & even_sel;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            state_q     <= fifo_pkg::IDLE;
            front_vld_q <= 1'b0;
            word_ok_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take) begin
                front_vld_q <= take_even;
            end else if (one_left_i) begin
                front_vld_q <= 1'b1;
            end
            if (state_q != fifo_pkg::NORMAL || one_left_i) begin
                word_ok_q <= 1'b0;
            end else if (rd_grant_i) begin
                word_ok_q <= 1'b1;
            end else if (take_even) begin
                word_ok_q <= 1'b0;
            end
        end
    end

    // Odd half after an even take, or a copy of the lone entry
    // so it survives a write that lands before it is taken
    always_ff @(posedge axis_clk) begin
        if (take_even) begin
            front_q <= rd_data_i.pair.odd;
        end else if (!take && one_left_i) begin
            front_q <= held_i;
        end
    end

endmodule

// ==== src/sram_fifo.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module sram_fifo (
    input  logic             axis_clk,
    input  logic             axi_reset_n,
    // Write side
    input  logic             w_vld_i,
    output logic             w_rdy_o,
    input  fifo_pkg::entry_t data_i,
    // Read side
    input  logic             r_rdy_i,
    output logic             r_vld_o,
    output fifo_pkg::entry_t data_o
);

    fifo_pkg::ptr_t         w_ptr;
    fifo_pkg::ptr_t         r_ptr;
    logic                   empty;
    logic                   full;
    logic                   one_left;
    logic                   wr_fire;
    logic                   rd_grant;
    fifo_pkg::entry_t       held;
    fifo_pkg::sram_wr_req_t wr_req;
    fifo_pkg::sram_rd_req_t rd_req;
    fifo_pkg::sram_word_u   rd_data;

    assign w_rdy_o = ~full;
    assign wr_fire = w_vld_i & w_rdy_o;

    fifo_ptrs ptrs_i (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .w_vld_i     (w_vld_i),
        .r_rdy_i     (r_rdy_i),
        .r_vld_i     (r_vld_o),
        .w_ptr_o     (w_ptr),
        .r_ptr_o     (r_ptr),
        .empty_o     (empty),
        .full_o      (full),
        .one_left_o  (one_left)
    );

    write_pairer pairer_i (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .wr_fire_i   (wr_fire),
        .w_ptr_i     (w_ptr),
        .data_i      (data_i),
        .held_o      (held),
        .wr_req_o    (wr_req)
    );

    read_sequencer seq_i (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .r_rdy_i     (r_rdy_i),
        .r_ptr_i     (r_ptr),
        .w_ptr_i     (w_ptr),
        .empty_i     (empty),
        .one_left_i  (one_left),
        .held_i      (held),
        .rd_grant_i  (rd_grant),
        .rd_data_i   (rd_data),
        .rd_req_o    (rd_req),
        .r_vld_o     (r_vld_o),
        .data_o      (data_o)
    );

    pair_sram sram_i (
        .axis_clk    (axis_clk),
        .wr_req_i    (wr_req),
        .rd_req_i    (rd_req),
        .rd_grant_o  (rd_grant),
        .rd_data_o   (rd_data)
    );

endmodule

// ==== bench/sram_fifo_tb.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module sram_fifo_tb;

    localparam int WAIT_LIMIT = 1000;

    logic             axis_clk;
    logic             axi_reset_n;
    logic             w_vld_i;
    logic             w_rdy_o;
    fifo_pkg::entry_t data_i;
    logic             r_rdy_i;
    logic             r_vld_o;
    fifo_pkg::entry_t data_o;

    fifo_pkg::entry_t ref_q[$];
    fifo_pkg::entry_t stalled_data;
    logic             stalled;
    string            test_name;
    int               seed;

    sram_fifo dut_i (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .w_vld_i     (w_vld_i),
        .w_rdy_o     (w_rdy_o),
        .data_i      (data_i),
        .r_rdy_i     (r_rdy_i),
        .r_vld_o     (r_vld_o),
        .data_o      (data_o)
    );

    always #50 axis_clk = ~axis_clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Oldest entry not yet read
    function automatic fifo_pkg::entry_t expected_next();
        return ref_q[0];
    endfunction

    function automatic fifo_pkg::entry_t random_entry();
        logic [63:0] bits;
        bits = {$random(seed), $random(seed)};
        return bits[`FIFO_WIDTH-1:0];
    endfunction

    // Outputs are settled at the falling edge, transfers happen on the next rising edge
    always @(negedge axis_clk) begin
        if (axi_reset_n) begin
            if (stalled) begin
                assert (r_vld_o) else
                    stop_run("r_vld_o dropped while the read side was stalled");
                assert (data_o == stalled_data) else
                    stop_run($sformatf("MISMATCH test=%s expected=%h actual=%h (stalled data)",
                                       test_name, stalled_data, data_o));
            end
            assert (w_rdy_o == (ref_q.size() != `FIFO_DEPTH)) else
                stop_run($sformatf("MISMATCH test=%s expected=%b actual=%b (w_rdy_o)",
                                   test_name, ref_q.size() != `FIFO_DEPTH, w_rdy_o));
            assert (!(r_vld_o && ref_q.size() == 0)) else
                stop_run("r_vld_o is high while the FIFO holds no entry");
            if (r_vld_o && r_rdy_i) begin
                assert (data_o == expected_next()) else
                    stop_run($sformatf("MISMATCH test=%s expected=%h actual=%h",
                                       test_name, expected_next(), data_o));
                void'(ref_q.pop_front());
            end
            if (w_vld_i && w_rdy_o) begin
                ref_q.push_back(data_i);
            end
            stalled      = r_vld_o && !r_rdy_i;
            stalled_data = data_o;
        end
    end

    task automatic push_one(input fifo_pkg::entry_t value);
        int waited;
        waited = 0;
        @(posedge axis_clk);
        w_vld_i <= 1'b1;
        data_i  <= value;
        @(negedge axis_clk);
        while (!w_rdy_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("write was not accepted before the timeout");
            end
            @(negedge axis_clk);
        end
        @(posedge axis_clk);
        w_vld_i <= 1'b0;
    endtask

    task automatic pop_one();
        int waited;
        waited = 0;
        @(posedge axis_clk);
        r_rdy_i <= 1'b1;
        @(negedge axis_clk);
        while (!r_vld_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("read data did not become valid before the timeout");
            end
            @(negedge axis_clk);
        end
        @(posedge axis_clk);
        r_rdy_i <= 1'b0;
    endtask

    task automatic drain_all();
        int waited;
        waited = 0;
        @(posedge axis_clk);
        r_rdy_i <= 1'b1;
        while (ref_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_run("FIFO did not drain before the timeout");
            end
            @(posedge axis_clk);
        end
        r_rdy_i <= 1'b0;
    endtask

    initial begin
        axis_clk    = 1'b0;
        axi_reset_n = 1'b0;
        w_vld_i     = 1'b0;
        r_rdy_i     = 1'b0;
        data_i      = '0;
        stalled     = 1'b0;
        seed        = 69;
        test_name   = "reset";
        repeat (5) @(posedge axis_clk);
        axi_reset_n <= 1'b1;

        @(negedge axis_clk);
        assert (!r_vld_o && w_rdy_o) else
            stop_run("r_vld_o or w_rdy_o is wrong after reset");

        test_name = "single_entry";
        push_one(random_entry());
        pop_one();
        @(negedge axis_clk);
        assert (!r_vld_o) else
            stop_run("r_vld_o stays high after the only entry was read");

        // Pointers now sit at an odd position
        test_name = "fill_to_full";
        repeat (`FIFO_DEPTH) push_one(random_entry());
        @(negedge axis_clk);
        assert (!w_rdy_o) else
            stop_run("w_rdy_o is high with 128 entries stored");
        @(posedge axis_clk);
        w_vld_i <= 1'b1;
        data_i  <= random_entry();
        repeat (3) @(posedge axis_clk);
        w_vld_i <= 1'b0;
        pop_one();
        @(negedge axis_clk);
        assert (w_rdy_o) else
            stop_run("w_rdy_o did not rise after a read from a full FIFO");

        test_name = "full_drain";
        drain_all();

        test_name = "random_traffic";
        for (int i = 0; i < 2000; i++) begin
            @(posedge axis_clk);
            // Write heavy first half fills the FIFO, read heavy second half empties it
            if (i < 1000) begin
                w_vld_i <= (($random(seed) & 3) != 0);
                r_rdy_i <= (($random(seed) & 3) == 0);
            end else begin
                w_vld_i <= (($random(seed) & 3) == 0);
                r_rdy_i <= (($random(seed) & 3) != 0);
            end
            data_i <= random_entry();
        end
        @(posedge axis_clk);
        w_vld_i <= 1'b0;
        r_rdy_i <= 1'b0;

        test_name = "final_drain";
        drain_all();
        @(negedge axis_clk);
        assert (!r_vld_o) else
            stop_run("r_vld_o stays high after every written entry was read");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/fifo_pkg.sv
src/pair_sram.sv
src/fifo_ptrs.sv
src/write_pairer.sv
src/read_sequencer.sv
src/sram_fifo.sv
bench/sram_fifo_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f vlog.f --top-module sram_fifo_tb \
        -o sram_fifo_sim \
    && ./obj_dir/sram_fifo_sim \
    || exit 1
